/* Makefile */
# Verilator simulation of the sine and cosine unit
TOP = trig_tb
BUILD = obj_dir

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf $(BUILD) sim.log

.PHONY: sim clean

/* test/trig_assertions.sv */
// ------------------------------
// trig_assertions: AXI4-Lite response
// and result queue checks
// ------------------------------
`timescale 1ns/1ps

module trig_assertions (
	input logic clk,
	input logic reset,
	input trig_pkg::axil_req_t axil_req,
	input trig_pkg::axil_rsp_t axil_rsp,
	input logic [2:0] count,
	input logic out_valid,
	input logic launch_valid
);
	import trig_pkg::*;

	// read by the testbench at the end of the run
	int unsigned fail_count = 0;

	b_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
		else begin
			fail_count++;
			$error("b_valid dropped before b_ready");
		end

	r_hold: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid)
		else begin
			fail_count++;
			$error("r_valid dropped before r_ready");
		end

	r_data_stable: assert property (@(posedge clk) disable iff (reset)
		axil_rsp.r_valid && !axil_req.r_ready |=> $stable(axil_rsp.r_data))
		else begin
			fail_count++;
			$error("r_data changed while waiting for r_ready");
		end

	count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= 3'(RESULT_DEPTH))
		else begin
			fail_count++;
			$error("result count above queue depth");
		end

	// queue full with a finished result means a frozen pipeline
	no_launch_stalled: assert property (@(posedge clk) disable iff (reset)
		count == 3'(RESULT_DEPTH) && out_valid |-> !launch_valid)
		else begin
			fail_count++;
			$error("angle launched while pipeline stalled");
		end

endmodule

/* test/trig_tb.sv */
// ------------------------------
// trig_tb: directed and random tests of
// the sine and cosine unit over AXI4-Lite
// ------------------------------
`timescale 1ns/1ps

module trig_tb;
	import trig_pkg::*;

	// accesses issued by the tests, status polls not included
	localparam int TRANSACTIONS = 136;
	localparam int MARGIN = 2;
	localparam int WATCHDOG_CYCLES = TRANSACTIONS * 200 * MARGIN;

	logic clk;
	logic reset;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;

	trig_top dut (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp)
	);

	bind trig_axil_regs trig_assertions u_assertions (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.count(count),
		.out_valid(out_valid),
		.launch_valid(launch_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// sign-extend the low 21 bits, Q5.16 wrap-around
	function automatic longint wrap_fix(input longint v);
		fix_t t;
		t = v[20:0];
		return longint'(t);
	endfunction

	function automatic longint round_product(input longint a, input longint b);
		longint full;
		full = a * b;
		return wrap_fix((full >>> 16) + ((full >>> 15) & 1));
	endfunction

	function automatic longint model_trig(input longint angle, input bit use_cos);
		longint x;
		longint sq_term;
		longint lin;
		longint est;
		longint est_sq;
		longint norm;
		x = angle + (use_cos ? HALF_PI_FIX : 0);
		while (x >= PI_FIX)
			x -= TWO_PI_FIX;
		while (x < -PI_FIX)
			x += TWO_PI_FIX;
		sq_term = round_product(round_product(x, x), COEFF_SQ);
		lin = round_product(x, COEFF_LIN);
		est = wrap_fix(x < 0 ? lin + sq_term : lin - sq_term);
		est_sq = round_product(est, est);
		norm = est < 0 ? wrap_fix(-est_sq) : est_sq;
		return wrap_fix(round_product(wrap_fix(norm - est), COEFF_REFINE) + est);
	endfunction

	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr = addr;
		axil_req.w_valid = 1'b1;
		axil_req.w_data = data;
		// b_valid rises on the edge that takes the write
		do
			@(negedge clk);
		while (!axil_rsp.b_valid);
		// a pending response holds the write channel off
		check_value("aw_ready", axil_rsp.aw_ready, 32'd0);
		check_value("w_ready", axil_rsp.w_ready, 32'd0);
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid = 1'b0;
		// let the response wait a little
		repeat ($urandom_range(2)) @(negedge clk);
		resp = axil_rsp.b_resp;
		axil_req.b_ready = 1'b1;
		@(negedge clk);
		axil_req.b_ready = 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr = addr;
		// r_valid rises on the edge that takes the address
		do
			@(negedge clk);
		while (!axil_rsp.r_valid);
		// a pending response holds the read channel off
		check_value("ar_ready", axil_rsp.ar_ready, 32'd0);
		axil_req.ar_valid = 1'b0;
		repeat ($urandom_range(2)) @(negedge clk);
		data = axil_rsp.r_data;
		resp = axil_rsp.r_resp;
		axil_req.r_ready = 1'b1;
		@(negedge clk);
		axil_req.r_ready = 1'b0;
	endtask

	task automatic set_mode(input bit use_cos);
		logic [1:0] resp;
		axil_write(ADDR_CTRL, {31'd0, use_cos}, resp);
		check_value("b_resp", resp, RESP_OKAY);
	endtask

	task automatic issue_angle(input longint angle);
		logic [1:0] resp;
		axil_write(ADDR_ANGLE, 32'(angle), resp);
		check_value("b_resp", resp, RESP_OKAY);
	endtask

	// poll STATUS until enough results are queued
	task automatic wait_results(input int min_count);
		logic [31:0] data;
		logic [1:0] resp;
		trig_status_t status;
		do begin
			axil_read(ADDR_STATUS, data, resp);
			status = data[4:0];
			if (status.count > 3'(RESULT_DEPTH))
				abort_run("result count went above the queue depth");
		end while (status.count < min_count);
	endtask

	task automatic read_and_compare(input longint angle, input bit use_cos);
		logic [31:0] data;
		logic [1:0] resp;
		wait_results(1);
		axil_read(ADDR_RESULT, data, resp);
		check_value("r_resp", resp, RESP_OKAY);
		check_value("r_data", data, 32'(model_trig(angle, use_cos)));
	endtask

	task automatic check_reset_state();
		logic [31:0] data;
		logic [1:0] resp;
		axil_read(ADDR_STATUS, data, resp);
		check_value("status", data, 32'd0);
		axil_read(ADDR_CTRL, data, resp);
		check_value("ctrl", data, 32'd0);
	endtask

	task automatic run_sine_angles();
		longint angles[6];
		// 0, 0.5, 1.0, -2.0, pi/2, -3.1
		angles = '{0, 32768, 65536, -131072, HALF_PI_FIX, -203162};
		set_mode(1'b0);
		foreach (angles[i]) begin
			issue_angle(angles[i]);
			read_and_compare(angles[i], 1'b0);
		end
	endtask

	task automatic run_cosine_angles();
		longint angles[3];
		// 10.0, -15.0, 15.9
		angles = '{655360, -983040, 1042022};
		set_mode(1'b1);
		foreach (angles[i]) begin
			issue_angle(angles[i]);
			read_and_compare(angles[i], 1'b1);
		end
	endtask

	task automatic fill_and_stall();
		longint angles[7];
		logic [31:0] data;
		logic [1:0] resp;
		trig_status_t status;
		bit write_done;
		angles = '{16384, -49152, 98304, -163840, 196608, -81920, 131072};
		write_done = 1'b0;
		set_mode(1'b0);
		for (int i = 0; i < 6; i++)
			issue_angle(angles[i]);
		wait_results(4);
		// results five and six stay parked in the frozen pipeline
		repeat (40) @(negedge clk);
		axil_read(ADDR_STATUS, data, resp);
		status = data[4:0];
		check_value("status.count", status.count, 32'd4);
		check_value("status.busy", status.busy, 32'd1);
		fork
			begin
				issue_angle(angles[6]);
				write_done = 1'b1;
			end
			begin
				repeat (20) @(negedge clk);
				if (write_done)
					abort_run("angle write was accepted while the queue was full");
				for (int i = 0; i < 7; i++)
					read_and_compare(angles[i], 1'b0);
			end
		join
	endtask

	task automatic probe_error_responses();
		logic [31:0] data;
		logic [1:0] resp;
		set_mode(1'b1);
		axil_read(ADDR_RESULT, data, resp);
		check_value("r_resp", resp, RESP_SLVERR);
		check_value("r_data", data, 32'd0);
		axil_write(ADDR_STATUS, 32'd0, resp);
		check_value("b_resp", resp, RESP_SLVERR);
		// 0x6 sits between the mapped registers
		axil_write(4'h6, 32'd0, resp);
		check_value("b_resp", resp, RESP_SLVERR);
		axil_read(4'h6, data, resp);
		check_value("r_resp", resp, RESP_SLVERR);
		axil_read(ADDR_ANGLE, data, resp);
		check_value("r_resp", resp, RESP_SLVERR);
		axil_read(ADDR_CTRL, data, resp);
		check_value("r_resp", resp, RESP_OKAY);
		check_value("ctrl", data, 32'd1);
		axil_read(ADDR_STATUS, data, resp);
		check_value("status", data, 32'd0);
	endtask

	task automatic run_random_angles();
		longint angle;
		bit use_cos;
		for (int i = 0; i < 30; i++) begin
			angle = longint'(fix_t'($urandom));
			use_cos = 1'($urandom_range(1));
			set_mode(use_cos);
			issue_angle(angle);
			read_and_compare(angle, use_cos);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(32'h4e59));
		axil_req = '0;
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		check_reset_state();
		run_sine_angles();
		run_cosine_angles();
		fill_and_stall();
		probe_error_responses();
		run_random_angles();
		if (dut.u_regs.u_assertions.fail_count != 0) begin
			abort_run("a protocol assertion failed during the run");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

/* verilog.f */
verilog/trig_pkg.sv
verilog/fixed_mult.sv
verilog/fixed_scale.sv
verilog/angle_wrap.sv
verilog/sine_pipe.sv
verilog/result_fifo.sv
verilog/trig_axil_regs.sv
verilog/trig_top.sv
test/trig_assertions.sv
test/trig_tb.sv

/* verilog/angle_wrap.sv */
// ------------------------------
// angle_wrap: optional quarter-turn shift,
// then fold into [-pi, pi), one stage
// ------------------------------
`timescale 1ns/1ps

module angle_wrap (
	input logic clk,
	input logic reset,
	input logic en,
	input logic in_valid,
	input logic cos_sel,
	input trig_pkg::fix_t angle,
	output logic out_valid,
	output trig_pkg::fix_t wrapped
);
	import trig_pkg::*;

	// two guard bits, input plus pi/2 reaches about 17.6
	logic signed [22:0] shifted;
	logic signed [22:0] folded;

	always_comb begin
		shifted = {{2{angle[20]}}, angle};
		// cos(x) = sin(x + pi/2)
		if (cos_sel)
			shifted = shifted + 23'(HALF_PI_FIX);
		// at most three turns either way for a Q5.16 input
		if (shifted >= PI_FIX + 2 * TWO_PI_FIX)
			folded = shifted - 23'(3 * TWO_PI_FIX);
		else if (shifted >= PI_FIX + TWO_PI_FIX)
			folded = shifted - 23'(2 * TWO_PI_FIX);
		else if (shifted >= PI_FIX)
			folded = shifted - 23'(TWO_PI_FIX);
		else if (shifted < -PI_FIX - 2 * TWO_PI_FIX)
			folded = shifted + 23'(3 * TWO_PI_FIX);
		else if (shifted < -PI_FIX - TWO_PI_FIX)
			folded = shifted + 23'(2 * TWO_PI_FIX);
		else if (shifted < -PI_FIX)
			folded = shifted + 23'(TWO_PI_FIX);
		else
			folded = shifted;
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else if (en)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (en)
			wrapped <= folded[20:0];
	end

endmodule

/* verilog/fixed_mult.sv */
// ------------------------------
// fixed_mult: signed Q5.16 product,
// three multiply stages and a rounding stage
// ------------------------------
`timescale 1ns/1ps

module fixed_mult (
	input logic clk,
	input logic en,
	input trig_pkg::fix_t a,
	input trig_pkg::fix_t b,
	output trig_pkg::fix_t p
);
	import trig_pkg::*;

	fix_t a_q;
	fix_t b_q;
	logic signed [2*$bits(fix_t)-1:0] prod_q;
	logic signed [2*$bits(fix_t)-1:0] prod_d;

	always_ff @(posedge clk) begin
		if (en) begin
			a_q <= a;
			b_q <= b;
			// full 42-bit signed product
			prod_q <= a_q * b_q;
			prod_d <= prod_q;
			// keep Q5.16 window, round half up, wrap to 21 bits
			p <= prod_d[FRAC_BITS +: $bits(fix_t)] + prod_d[FRAC_BITS-1];
		end
	end

endmodule

/* verilog/fixed_scale.sv */
// ------------------------------
// fixed_scale: Q5.16 operand times a
// constant coefficient, four stages
// ------------------------------
`timescale 1ns/1ps

module fixed_scale #(
	parameter trig_pkg::fix_t COEFF = '0
) (
	input logic clk,
	input logic en,
	input trig_pkg::fix_t a,
	output trig_pkg::fix_t p
);
	import trig_pkg::*;

	fix_t a_q;
	logic signed [2*$bits(fix_t)-1:0] prod_q;
	logic signed [2*$bits(fix_t)-1:0] prod_d;

	always_ff @(posedge clk) begin
		if (en) begin
			a_q <= a;
			prod_q <= a_q * COEFF;
			prod_d <= prod_q;
			// same rounding as fixed_mult
			p <= prod_d[FRAC_BITS +: $bits(fix_t)] + prod_d[FRAC_BITS-1];
		end
	end

endmodule

/* verilog/result_fifo.sv */
// ------------------------------
// result_fifo: four-entry result queue
// with occupancy count
// ------------------------------
`timescale 1ns/1ps

module result_fifo (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input trig_pkg::fix_t push_data,
	output trig_pkg::fix_t head,
	output logic [2:0] count,
	output logic full
);
	import trig_pkg::*;

	fix_t mem [RESULT_DEPTH];
	logic [$clog2(RESULT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(RESULT_DEPTH)-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = count == 3'(RESULT_DEPTH);
	// a push while full is dropped, the pipeline is already stalled then
	assign do_push = push && !full;
	assign do_pop = pop && (count != 3'd0);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 3'd0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + 3'(do_push) - 3'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

/* verilog/sine_pipe.sv */
// ------------------------------
// sine_pipe: parabola sine estimate with
// one refinement step, 20 enabled stages
// ------------------------------
`timescale 1ns/1ps

module sine_pipe (
	input logic clk,
	input logic reset,
	input logic en,
	input logic in_valid,
	input trig_pkg::fix_t angle,
	output logic out_valid,
	output trig_pkg::fix_t sin
);
	import trig_pkg::*;

	fix_t angle_sq;
	fix_t sq_term;
	fix_t lin_term;
	fix_t [MULT_LATENCY-1:0] lin_d;
	fix_t [2*MULT_LATENCY-1:0] angle_d;
	fix_t est;
	fix_t [9:0] est_d;
	fix_t est_sq;
	fix_t est_norm;
	fix_t diff;
	fix_t refine;
	logic [SINE_LATENCY-1:0] valid_d;

	// x * x, ready at stage 4
	fixed_mult u_angle_sq (
		.clk(clk),
		.en(en),
		.a(angle),
		.b(angle),
		.p(angle_sq)
	);

	// 0.405 * x * x, stage 8
	fixed_scale #(.COEFF(COEFF_SQ)) u_sq_term (
		.clk(clk),
		.en(en),
		.a(angle_sq),
		.p(sq_term)
	);

	// 1.273 * x, stage 4, delayed to meet the square term
	fixed_scale #(.COEFF(COEFF_LIN)) u_lin_term (
		.clk(clk),
		.en(en),
		.a(angle),
		.p(lin_term)
	);

	always_ff @(posedge clk) begin
		if (en) begin
			angle_d <= {angle_d[2*MULT_LATENCY-2:0], angle};
			lin_d <= {lin_d[MULT_LATENCY-2:0], lin_term};
			// parabola term flips sign with the angle, stage 9
			est <= angle_d[2*MULT_LATENCY-1][20] ? lin_d[MULT_LATENCY-1] + sq_term
				: lin_d[MULT_LATENCY-1] - sq_term;
			est_d <= {est_d[8:0], est};
		end
	end

	// est * est, stage 13
	fixed_mult u_est_sq (
		.clk(clk),
		.en(en),
		.a(est),
		.b(est),
		.p(est_sq)
	);

	always_ff @(posedge clk) begin
		if (en) begin
			// est * |est|, stage 14
			est_norm <= est_d[3][20] ? -est_sq : est_sq;
			diff <= est_norm - est_d[4];
		end
	end

	// 0.225 * (est * |est| - est), stage 19
	fixed_scale #(.COEFF(COEFF_REFINE)) u_refine (
		.clk(clk),
		.en(en),
		.a(diff),
		.p(refine)
	);

	always_ff @(posedge clk) begin
		if (en)
			sin <= refine + est_d[9];
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid_d <= '0;
		else if (en)
			valid_d <= {valid_d[SINE_LATENCY-2:0], in_valid};
	end

	assign out_valid = valid_d[SINE_LATENCY-1];

endmodule

/* verilog/trig_axil_regs.sv */
// ------------------------------
// trig_axil_regs: AXI4-Lite slave, angle
// launch, result pop and pipeline stall
// ------------------------------
`timescale 1ns/1ps

module trig_axil_regs (
	input logic clk,
	input logic reset,
	input trig_pkg::axil_req_t axil_req,
	output trig_pkg::axil_rsp_t axil_rsp,
	input logic out_valid,
	input logic full,
	input logic [2:0] count,
	input trig_pkg::fix_t head,
	output logic en,
	output logic launch_valid,
	output logic cos_sel,
	output logic pop,
	output trig_pkg::fix_t launch_angle
);
	import trig_pkg::*;

	logic wr_ready;
	logic wr_ok;
	logic rd_fire;
	logic b_valid;
	logic [1:0] b_resp;
	logic r_valid;
	logic [AXIL_DATA_W-1:0] r_data;
	logic [1:0] r_resp;
	logic [AXIL_DATA_W-1:0] rd_data;
	logic [1:0] rd_resp;
	logic [$clog2(SINE_LATENCY + 2)-1:0] in_flight;
	trig_status_t status;

	// freeze everything when a finished result has no room
	assign en = !(full && out_valid);

	// address and data accepted together, one response at a time
	assign wr_ready = axil_req.aw_valid && axil_req.w_valid && !b_valid && en;
	assign wr_ok = (axil_req.aw_addr == ADDR_ANGLE) || (axil_req.aw_addr == ADDR_CTRL);
	assign launch_valid = wr_ready && (axil_req.aw_addr == ADDR_ANGLE);
	assign launch_angle = axil_req.w_data[20:0];

	assign rd_fire = axil_req.ar_valid && !r_valid;
	assign pop = rd_fire && (axil_req.ar_addr == ADDR_RESULT) && (count != 3'd0);

	assign status = '{busy: in_flight != '0, spare: 1'b0, count: count};

	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (axil_req.ar_addr)
			ADDR_CTRL: rd_data = {31'd0, cos_sel};
			ADDR_STATUS: rd_data = 32'(status);
			ADDR_RESULT: begin
				if (count != 3'd0)
					rd_data = {{11{head[20]}}, head};
				else
					rd_resp = RESP_SLVERR;
			end
			// angle is write-only
			default: rd_resp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			b_valid <= 1'b0;
			r_valid <= 1'b0;
			cos_sel <= 1'b0;
			in_flight <= '0;
		end else begin
			if (wr_ready)
				b_valid <= 1'b1;
			else if (axil_req.b_ready)
				b_valid <= 1'b0;
			if (rd_fire)
				r_valid <= 1'b1;
			else if (axil_req.r_ready)
				r_valid <= 1'b0;
			if (wr_ready && axil_req.aw_addr == ADDR_CTRL)
				cos_sel <= axil_req.w_data[0];
			// launches in, pushes out
			in_flight <= in_flight + $bits(in_flight)'(launch_valid)
				- $bits(in_flight)'(out_valid && en);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ready)
			b_resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire) begin
			r_data <= rd_data;
			r_resp <= rd_resp;
		end
	end

	assign axil_rsp = '{
		aw_ready: wr_ready,
		w_ready: wr_ready,
		b_valid: b_valid,
		b_resp: b_resp,
		ar_ready: !r_valid,
		r_valid: r_valid,
		r_data: r_data,
		r_resp: r_resp
	};

endmodule

/* verilog/trig_pkg.sv */
// ------------------------------
// trig package: Q5.16 type, constants,
// register map and AXI4-Lite structs
// ------------------------------
package trig_pkg;

	// signed Q5.16 radians and results
	typedef logic signed [20:0] fix_t;

	localparam int FRAC_BITS = 16;
	localparam int MULT_LATENCY = 4;
	localparam int SINE_LATENCY = 20;

	// 4/pi, 4/pi^2 and the refinement weight
	localparam fix_t COEFF_LIN = 21'sd83443;
	localparam fix_t COEFF_SQ = 21'sd26561;
	localparam fix_t COEFF_REFINE = 21'sd14746;

	localparam int PI_FIX = 205887;
	localparam int TWO_PI_FIX = 411775;
	localparam int HALF_PI_FIX = 102944;

	localparam int RESULT_DEPTH = 4;

	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;

	localparam logic [AXIL_ADDR_W-1:0] ADDR_ANGLE = 4'h0;
	localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL = 4'h4;
	localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 4'h8;
	localparam logic [AXIL_ADDR_W-1:0] ADDR_RESULT = 4'hC;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic aw_valid;
		logic [AXIL_ADDR_W-1:0] aw_addr;
		logic w_valid;
		logic [AXIL_DATA_W-1:0] w_data;
		logic b_ready;
		logic ar_valid;
		logic [AXIL_ADDR_W-1:0] ar_addr;
		logic r_ready;
	} axil_req_t;

	typedef struct packed {
		logic aw_ready;
		logic w_ready;
		logic b_valid;
		logic [1:0] b_resp;
		logic ar_ready;
		logic r_valid;
		logic [AXIL_DATA_W-1:0] r_data;
		logic [1:0] r_resp;
	} axil_rsp_t;

	typedef struct packed {
		logic busy;
		logic spare;
		logic [2:0] count;
	} trig_status_t;

endpackage

/* verilog/trig_top.sv */
// ------------------------------
// trig_top: memory-mapped sine and
// cosine unit
// ------------------------------
`timescale 1ns/1ps

module trig_top (
	input logic clk,
	input logic reset,
	input trig_pkg::axil_req_t axil_req,
	output trig_pkg::axil_rsp_t axil_rsp
);
	import trig_pkg::*;

	logic en;
	logic launch_valid;
	fix_t launch_angle;
	logic cos_sel;
	logic wrap_valid;
	fix_t wrap_angle;
	logic sin_valid;
	fix_t sin_value;
	logic pop;
	fix_t head;
	logic [2:0] count;
	logic full;

	trig_axil_regs u_regs (
		.clk(clk),
		.reset(reset),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.out_valid(sin_valid),
		.full(full),
		.count(count),
		.head(head),
		.en(en),
		.launch_valid(launch_valid),
		.cos_sel(cos_sel),
		.pop(pop),
		.launch_angle(launch_angle)
	);

	angle_wrap u_wrap (
		.clk(clk),
		.reset(reset),
		.en(en),
		.in_valid(launch_valid),
		.cos_sel(cos_sel),
		.angle(launch_angle),
		.out_valid(wrap_valid),
		.wrapped(wrap_angle)
	);

	sine_pipe u_sine (
		.clk(clk),
		.reset(reset),
		.en(en),
		.in_valid(wrap_valid),
		.angle(wrap_angle),
		.out_valid(sin_valid),
		.sin(sin_value)
	);

	// en only drops when full, so the queue's own full check matches out_valid and en
	result_fifo u_fifo (
		.clk(clk),
		.reset(reset),
		.push(sin_valid),
		.pop(pop),
		.push_data(sin_value),
		.head(head),
		.count(count),
		.full(full)
	);

endmodule
